//--- src/stream_demux_pkg.sv
`default_nettype none

package stream_demux_pkg;

	//////////////////////////////////////////////////
	// stream geometry

	localparam int DATA_W = 64;
	localparam int STRB_W = DATA_W / 8;
	localparam int LEN_W  = 16;
	localparam int PORT_W = 8;

	// channels 0..3 are the regular ports, the last one takes everything else
	localparam int NUM_CH = 5;
	localparam int EXC_CH = 4;

	//////////////////////////////////////////////////
	// packed beat layout, low bits first
	// each sideband field sits just above its valid bit

	localparam int OFS_STRB = 0;
	localparam int OFS_DATA = OFS_STRB + STRB_W;
	localparam int OFS_LAST = OFS_DATA + DATA_W;
	localparam int OFS_LEN  = OFS_LAST + 1;
	localparam int OFS_SPT  = OFS_LEN + LEN_W + 1;
	localparam int OFS_DPT  = OFS_SPT + PORT_W + 1;
	localparam int OFS_ERR  = OFS_DPT + PORT_W + 1;
	localparam int BEAT_W   = OFS_ERR + 2;

	//////////////////////////////////////////////////
	// vector types

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [LEN_W-1:0]  len_t;
	typedef logic [PORT_W-1:0] port_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [NUM_CH-1:0] ch_mask_t;

endpackage

`default_nettype wire

//--- src/beat_capture.sv
`timescale 1ns/100ps
`default_nettype none

module beat_capture
(
	input  logic                      ACLK,
	input  logic                      rst_n,
	input  logic                      in_valid,
	input  logic                      in_ready,
	input  stream_demux_pkg::data_t   in_data,
	input  stream_demux_pkg::strb_t   in_strb,
	input  logic                      in_last,
	input  stream_demux_pkg::len_t    in_len,
	input  logic                      in_len_valid,
	input  stream_demux_pkg::port_t   in_spt,
	input  logic                      in_spt_valid,
	input  stream_demux_pkg::port_t   in_dpt,
	input  logic                      in_dpt_valid,
	input  logic                      in_err,
	input  logic                      in_err_valid,
	output logic                      cap_valid,
	output stream_demux_pkg::beat_t   cap_beat,
	output stream_demux_pkg::port_t   cap_dest
);

	import stream_demux_pkg::*;

	logic  accept;
	port_t dest_hold;
	port_t beat_dest;
	beat_t beat_packed;

	assign accept = in_valid && in_ready;

	// a dest on the beat itself applies to that same beat
	assign beat_dest = in_dpt_valid ? in_dpt : dest_hold;

	//////////////////////////////////////////////////
	// pack the beat by the package offsets

	always_comb
	begin
		beat_packed = '0;
		beat_packed[OFS_STRB +: STRB_W] = in_strb;
		beat_packed[OFS_DATA +: DATA_W] = in_data;
		beat_packed[OFS_LAST]           = in_last;
		beat_packed[OFS_LEN]            = in_len_valid;
		beat_packed[OFS_LEN+1 +: LEN_W] = in_len;
		beat_packed[OFS_SPT]            = in_spt_valid;
		beat_packed[OFS_SPT+1 +: PORT_W] = in_spt;
		beat_packed[OFS_DPT]            = in_dpt_valid;
		beat_packed[OFS_DPT+1 +: PORT_W] = in_dpt;
		beat_packed[OFS_ERR]            = in_err_valid;
		beat_packed[OFS_ERR+1]          = in_err;
	end

	//////////////////////////////////////////////////
	// capture stage

	always_ff @(posedge ACLK)
	begin
		if (!rst_n)
		begin
			cap_valid <= 1'b0;
			dest_hold <= '0;
		end
		else
		begin
			cap_valid <= accept;
			// held until the next beat that carries a dest
			if (accept)
				dest_hold <= beat_dest;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (accept)
		begin
			cap_beat <= beat_packed;
			cap_dest <= beat_dest;
		end
	end

endmodule

`default_nettype wire

//--- src/channel_select.sv
`timescale 1ns/100ps
`default_nettype none

module channel_select
#(
	parameter int DEPTH = 16
)
(
	input  logic                          ACLK,
	input  logic                          rst_n,
	input  logic                          cap_valid,
	input  stream_demux_pkg::port_t       cap_dest,
	input  logic [stream_demux_pkg::NUM_CH-1:0][$clog2(DEPTH+1)-1:0] fifo_count,
	output stream_demux_pkg::ch_mask_t    wr_en,
	output logic                          in_ready
);

	import stream_demux_pkg::*;

	localparam int SEL_W = $clog2(NUM_CH);

	logic [SEL_W-1:0] sel;
	logic             room_ok;

	//////////////////////////////////////////////////
	// destination decode

	always_comb
	begin
		case (cap_dest)
			8'h01:   sel = SEL_W'(0);
			8'h02:   sel = SEL_W'(1);
			8'h04:   sel = SEL_W'(2);
			8'h08:   sel = SEL_W'(3);
			// zero, multi-bit and high codes all go here
			default: sel = SEL_W'(EXC_CH);
		endcase
	end

	// one-hot write strobe, only for a captured beat
	assign wr_en = cap_valid ? (ch_mask_t'(1) << sel) : '0;

	//////////////////////////////////////////////////
	// input back-pressure

	// the write leaving the capture stage this cycle is counted too,
	// so the registered ready sees the occupancy after this edge
	always_comb
	begin
		room_ok = 1'b1;
		for (int i = 0; i < NUM_CH; i++)
		begin
			if (int'(fifo_count[i]) + int'(wr_en[i]) > DEPTH - 2)
				room_ok = 1'b0;
		end
	end

	// two free entries cover the captured beat and one more accepted
	always_ff @(posedge ACLK)
	begin
		if (!rst_n)
			in_ready <= 1'b1;
		else
			in_ready <= room_ok;
	end

endmodule

`default_nettype wire

//--- src/port_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module port_fifo
#(
	parameter int DEPTH = 16
)
(
	input  logic                         ACLK,
	input  logic                         rst_n,
	input  logic                         wr_en,
	input  stream_demux_pkg::beat_t      din,
	input  logic                         rd_ready,
	output stream_demux_pkg::beat_t      dout,
	output logic                         rd_valid,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	import stream_demux_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH+1);

	beat_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             pop;

	//////////////////////////////////////////////////
	// head falls through to the output

	assign rd_valid = (count != '0);
	assign pop      = rd_valid && rd_ready;
	assign dout     = mem[rd_ptr];

	// storage only, the pointers say what is live
	always_ff @(posedge ACLK)
	begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	//////////////////////////////////////////////////
	// pointers and occupancy

	always_ff @(posedge ACLK)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				// wrap by compare, depth need not be a power of two
				if (wr_ptr == PTR_W'(DEPTH-1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (pop)
			begin
				if (rd_ptr == PTR_W'(DEPTH-1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// push and pop together leave the count alone
			case ({wr_en, pop})
				2'b10:   count <= count + CNT_W'(1);
				2'b01:   count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/stream_demux_top.sv
`timescale 1ns/100ps
`default_nettype none

module stream_demux_top
#(
	parameter int FIFO_DEPTH = 16
)
(
	input  logic                         ACLK,
	input  logic                         rst_n,

	// input stream
	input  logic                         in_valid,
	output logic                         in_ready,
	input  stream_demux_pkg::data_t      in_data,
	input  stream_demux_pkg::strb_t      in_strb,
	input  logic                         in_last,
	input  stream_demux_pkg::len_t       in_len,
	input  logic                         in_len_valid,
	input  stream_demux_pkg::port_t      in_spt,
	input  logic                         in_spt_valid,
	input  stream_demux_pkg::port_t      in_dpt,
	input  logic                         in_dpt_valid,
	input  logic                         in_err,
	input  logic                         in_err_valid,

	// output channels, indexed by channel
	output stream_demux_pkg::ch_mask_t   out_valid,
	input  stream_demux_pkg::ch_mask_t   out_ready,
	output stream_demux_pkg::data_t [stream_demux_pkg::NUM_CH-1:0] out_data,
	output stream_demux_pkg::strb_t [stream_demux_pkg::NUM_CH-1:0] out_strb,
	output stream_demux_pkg::ch_mask_t   out_last,
	output stream_demux_pkg::len_t  [stream_demux_pkg::NUM_CH-1:0] out_len,
	output stream_demux_pkg::ch_mask_t   out_len_valid,
	output stream_demux_pkg::port_t [stream_demux_pkg::NUM_CH-1:0] out_spt,
	output stream_demux_pkg::ch_mask_t   out_spt_valid,
	output stream_demux_pkg::port_t [stream_demux_pkg::NUM_CH-1:0] out_dpt,
	output stream_demux_pkg::ch_mask_t   out_dpt_valid,
	output stream_demux_pkg::ch_mask_t   out_err,
	output stream_demux_pkg::ch_mask_t   out_err_valid
);

	import stream_demux_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH+1);

	logic                         cap_valid;
	beat_t                        cap_beat;
	port_t                        cap_dest;
	ch_mask_t                     wr_en;
	logic [NUM_CH-1:0][CNT_W-1:0] fifo_count;
	beat_t [NUM_CH-1:0]           fifo_head;

	//////////////////////////////////////////////////
	// capture and routing

	beat_capture u_capture (
		.ACLK         (ACLK),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_data      (in_data),
		.in_strb      (in_strb),
		.in_last      (in_last),
		.in_len       (in_len),
		.in_len_valid (in_len_valid),
		.in_spt       (in_spt),
		.in_spt_valid (in_spt_valid),
		.in_dpt       (in_dpt),
		.in_dpt_valid (in_dpt_valid),
		.in_err       (in_err),
		.in_err_valid (in_err_valid),
		.cap_valid    (cap_valid),
		.cap_beat     (cap_beat),
		.cap_dest     (cap_dest)
	);

	channel_select #(.DEPTH(FIFO_DEPTH)) u_select (
		.ACLK       (ACLK),
		.rst_n      (rst_n),
		.cap_valid  (cap_valid),
		.cap_dest   (cap_dest),
		.fifo_count (fifo_count),
		.wr_en      (wr_en),
		.in_ready   (in_ready)
	);

	//////////////////////////////////////////////////
	// per channel FIFO and head unpacking

	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		port_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
			.ACLK     (ACLK),
			.rst_n    (rst_n),
			.wr_en    (wr_en[i]),
			.din      (cap_beat),
			.rd_ready (out_ready[i]),
			.dout     (fifo_head[i]),
			.rd_valid (out_valid[i]),
			.count    (fifo_count[i])
		);

		assign out_strb[i]      = fifo_head[i][OFS_STRB +: STRB_W];
		assign out_data[i]      = fifo_head[i][OFS_DATA +: DATA_W];
		assign out_last[i]      = fifo_head[i][OFS_LAST];
		assign out_len_valid[i] = fifo_head[i][OFS_LEN];
		assign out_len[i]       = fifo_head[i][OFS_LEN+1 +: LEN_W];
		assign out_spt_valid[i] = fifo_head[i][OFS_SPT];
		assign out_spt[i]       = fifo_head[i][OFS_SPT+1 +: PORT_W];
		assign out_dpt_valid[i] = fifo_head[i][OFS_DPT];
		assign out_dpt[i]       = fifo_head[i][OFS_DPT+1 +: PORT_W];
		assign out_err_valid[i] = fifo_head[i][OFS_ERR];
		assign out_err[i]       = fifo_head[i][OFS_ERR+1];
	end

endmodule

`default_nettype wire

//--- test/stream_demux_checker.sv
`timescale 1ns/100ps
`default_nettype none

module stream_demux_checker
#(
	parameter int DEPTH = 16
)
(
	input logic                         ACLK,
	input logic                         rst_n,
	input logic                         in_ready,
	input stream_demux_pkg::ch_mask_t   out_valid,
	input stream_demux_pkg::ch_mask_t   out_ready,
	input logic [stream_demux_pkg::NUM_CH-1:0][$clog2(DEPTH+1)-1:0] fifo_count,
	input stream_demux_pkg::beat_t [stream_demux_pkg::NUM_CH-1:0]   fifo_head
);

	import stream_demux_pkg::*;

	// first cycle out of reset: idle outputs, input open
	assert property (@(posedge ACLK) $rose(rst_n) |-> (out_valid == '0 && in_ready))
	else $error("outputs not idle in the cycle after reset release");

	for (genvar i = 0; i < NUM_CH; i++)
	begin : g_ch
		// a stalled head holds still
		assert property (@(posedge ACLK) disable iff (!rst_n)
			out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(fifo_head[i]))
		else $error("channel %0d head changed while stalled", i);

		assert property (@(posedge ACLK) disable iff (!rst_n) int'(fifo_count[i]) <= DEPTH)
		else $error("channel %0d occupancy above depth", i);
	end

endmodule

bind stream_demux_top stream_demux_checker #(.DEPTH(FIFO_DEPTH)) u_checker (
	.ACLK       (ACLK),
	.rst_n      (rst_n),
	.in_ready   (in_ready),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.fifo_count (fifo_count),
	.fifo_head  (fifo_head)
);

`default_nettype wire

//--- test/stream_demux_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stream_demux_tb;

	import stream_demux_pkg::*;

	localparam int WAIT_LIMIT = 2000;
	localparam int REC_W      = DATA_W + STRB_W + LEN_W + 2 * PORT_W + 6;

	typedef logic [REC_W-1:0] rec_t;

	logic  ACLK;
	logic  rst_n;
	logic  in_valid;
	logic  in_ready;
	data_t in_data;
	strb_t in_strb;
	logic  in_last;
	len_t  in_len;
	port_t in_spt;
	port_t in_dpt;
	logic  in_len_valid, in_spt_valid, in_dpt_valid, in_err, in_err_valid;

	ch_mask_t              out_valid;
	ch_mask_t              out_ready = '0;
	data_t [NUM_CH-1:0]    out_data;
	strb_t [NUM_CH-1:0]    out_strb;
	len_t  [NUM_CH-1:0]    out_len;
	port_t [NUM_CH-1:0]    out_spt;
	port_t [NUM_CH-1:0]    out_dpt;
	ch_mask_t              out_last, out_len_valid, out_spt_valid;
	ch_mask_t              out_dpt_valid, out_err, out_err_valid;

	// model state
	rec_t     exp_q [NUM_CH][$];
	port_t    held_dest = '0;
	ch_mask_t stall_mask = '0;
	string    cur_test = "";
	int       errors, beats_in, beats_out, tests_run, in_base, err_base;
	logic     aborted = 1'b0;

	stream_demux_top #(.FIFO_DEPTH(16)) dut (.*);

	initial
	begin
		ACLK = 1'b0;
		forever #2 ACLK = ~ACLK;
	end

	// random sink ready with stalled channels held low
	always @(posedge ACLK)
	begin
		if (!rst_n)
			out_ready <= '0;
		else
			out_ready <= ch_mask_t'($urandom) & ~stall_mask;
	end

	function automatic int channel_of(input port_t code);
		for (int i = 0; i < 4; i++)
			if (code == port_t'(1 << i))
				return i;
		return EXC_CH;
	endfunction

	function automatic rec_t input_record();
		return {in_data, in_strb, in_last, in_len, in_len_valid, in_spt, in_spt_valid,
			in_dpt, in_dpt_valid, in_err, in_err_valid};
	endfunction

	function automatic rec_t output_record(input int c);
		return {out_data[c], out_strb[c], out_last[c], out_len[c], out_len_valid[c],
			out_spt[c], out_spt_valid[c], out_dpt[c], out_dpt_valid[c], out_err[c],
			out_err_valid[c]};
	endfunction

	//////////////////////////////////////////////////
	// reference model and output compare

	always @(posedge ACLK)
	begin
		port_t dest;
		rec_t  want;
		if (!rst_n)
			held_dest = '0;
		else
		begin
			if (in_valid && in_ready)
			begin
				dest = in_dpt_valid ? in_dpt : held_dest;
				held_dest = dest;
				exp_q[channel_of(dest)].push_back(input_record());
				beats_in++;
			end
			for (int c = 0; c < NUM_CH; c++)
			begin
				if (out_valid[c] && out_ready[c])
				begin
					if (exp_q[c].size() == 0)
					begin
						$display("channel %0d delivered a beat that was never routed to it", c);
						errors++;
					end
					else
					begin
						want = exp_q[c].pop_front();
						beats_out++;
						assert (output_record(c) == want)
						else
						begin
							$display("FAILED %s ch%0d expected %h actual %h",
								cur_test, c, want, output_record(c));
							errors++;
						end
					end
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers

	task automatic report_timeout(input string what);
		$display("timeout in test %s: %s", cur_test, what);
		errors++;
		aborted = 1'b1;
	endtask

	task automatic drive_fields(input port_t dpt, input logic dpt_v, input logic last);
		in_data      <= {$urandom, $urandom};
		in_strb      <= strb_t'($urandom);
		in_last      <= last;
		in_len       <= len_t'($urandom);
		in_len_valid <= 1'($urandom);
		in_spt       <= port_t'($urandom);
		in_spt_valid <= 1'($urandom);
		in_dpt       <= dpt;
		in_dpt_valid <= dpt_v;
		in_err       <= 1'($urandom);
		in_err_valid <= 1'($urandom);
	endtask

	task automatic send_beat(input port_t dpt, input logic dpt_v, input logic last);
		int waited;
		if (aborted)
			return;
		drive_fields(dpt, dpt_v, last);
		in_valid <= 1'b1;
		waited = 0;
		@(posedge ACLK);
		while (!in_ready)
		begin
			if (waited == WAIT_LIMIT)
			begin
				report_timeout("input handshake never completed");
				in_valid <= 1'b0;
				return;
			end
			waited++;
			@(posedge ACLK);
		end
		in_valid <= 1'b0;
	endtask

	// only the first beat may carry a destination
	// later beats carry a random code without its valid bit
	task automatic send_packet(input port_t dest, input logic with_dest, input int nbeats);
		for (int b = 0; b < nbeats; b++)
		begin
			if (b == 0 && with_dest)
				send_beat(dest, 1'b1, b == nbeats - 1);
			else
				send_beat(port_t'($urandom), 1'b0, b == nbeats - 1);
		end
	endtask

	function automatic port_t exception_code(input int k);
		port_t code;
		case (k % 4)
			0: code = 8'h00;
			1: code = 8'h03;
			2: code = 8'h80;
			default:
			begin
				code = port_t'($urandom);
				if (code inside {8'h01, 8'h02, 8'h04, 8'h08})
					code = 8'hff;
			end
		endcase
		return code;
	endfunction

	task automatic wait_drained();
		int waited;
		if (aborted)
			return;
		waited = 0;
		// one edge first so the last accepted beat is already queued
		@(posedge ACLK);
		while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size()
			+ exp_q[4].size() != 0)
		begin
			if (waited == WAIT_LIMIT)
			begin
				report_timeout("channel queues never drained");
				return;
			end
			waited++;
			@(posedge ACLK);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		in_base  = beats_in;
		err_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s done: %0d beats, %0d errors", cur_test, beats_in - in_base,
			errors - err_base);
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial
	begin
		port_t dest;
		int    waited;
		logic  saw_stall;
		void'($urandom(32'h1ee9));
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_data      = '0;
		in_strb      = '0;
		in_last      = 1'b0;
		in_len       = '0;
		in_len_valid = 1'b0;
		in_spt       = '0;
		in_spt_valid = 1'b0;
		in_dpt       = '0;
		in_dpt_valid = 1'b0;
		in_err       = 1'b0;
		in_err_valid = 1'b0;
		repeat (16) @(posedge ACLK);
		rst_n <= 1'b1;

		begin_test("reset_state");
		@(posedge ACLK);
		assert (in_ready && out_valid == '0)
		else
		begin
			$display("FAILED %s expected ready/valid 1/%b actual %b/%b", cur_test,
				ch_mask_t'(0), in_ready, out_valid);
			errors++;
		end
		end_test();

		begin_test("routing");
		for (int i = 0; i < 24; i++)
			send_packet(port_t'(1 << (i % 4)), 1'b1, int'($urandom % 6) + 1);
		wait_drained();
		end_test();

		begin_test("exception");
		for (int i = 0; i < 16; i++)
			send_packet(exception_code(i), 1'b1, int'($urandom % 4) + 1);
		wait_drained();
		end_test();

		// later packets carry no destination and follow the held one
		begin_test("held_dest");
		for (int i = 0; i < 8; i++)
		begin
			dest = (i % 2) ? exception_code(i) : port_t'(1 << ((i / 2) % 4));
			send_packet(dest, 1'b1, 2);
			send_packet(8'h00, 1'b0, int'($urandom % 4) + 1);
			send_packet(8'h00, 1'b0, 1);
		end
		wait_drained();
		end_test();

		begin_test("pass_through");
		for (int i = 0; i < 40; i++)
		begin
			dest = ($urandom % 3 == 0) ? exception_code(i) : port_t'(1 << ($urandom % 4));
			send_beat(dest, 1'($urandom), 1'($urandom));
		end
		wait_drained();
		end_test();

		// channel 1 stalled until the input closes
		begin_test("back_pressure");
		stall_mask <= 5'b00010;
		drive_fields(8'h02, 1'b1, 1'b0);
		in_valid  <= 1'b1;
		saw_stall = 1'b0;
		waited    = 0;
		while (!saw_stall && waited < WAIT_LIMIT)
		begin
			@(posedge ACLK);
			if (in_ready)
				drive_fields(8'h02, 1'b1, ($urandom % 4) == 0);
			else
				saw_stall = 1'b1;
			waited++;
		end
		assert (saw_stall)
		else
		begin
			$display("in_ready never dropped while channel 1 was stalled");
			errors++;
		end
		repeat (8)
		begin
			@(posedge ACLK);
			assert (!in_ready)
			else
			begin
				$display("in_ready reopened while channel 1 was still stalled");
				errors++;
			end
		end
		stall_mask <= '0;
		waited = 0;
		@(posedge ACLK);
		while (!in_ready && waited < WAIT_LIMIT)
		begin
			waited++;
			@(posedge ACLK);
		end
		in_valid <= 1'b0;
		if (!in_ready)
			report_timeout("input stayed closed after the stall was released");
		wait_drained();
		// nothing may be left in the DUT once the model has drained
		@(posedge ACLK);
		assert (out_valid == '0)
		else
		begin
			$display("FAILED %s expected out_valid=%b actual out_valid=%b", cur_test,
				ch_mask_t'(0), out_valid);
			errors++;
		end
		end_test();

		$display("%0d tests, %0d beats sent, %0d beats received, %0d errors", tests_run,
			beats_in, beats_out, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- stream_demux_top.f
src/stream_demux_pkg.sv
src/beat_capture.sv
src/channel_select.sv
src/port_fifo.sv
src/stream_demux_top.sv
test/stream_demux_checker.sv
test/stream_demux_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= stream_demux_tb
FILELIST  ?= stream_demux_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
